/* sources.f */
common/video_pkg.sv
common/vision_pkg.sv
vga/vga_timing.sv
vga/frame_address_gen.sv
target/orange_marker.sv
target/direction_classifier.sv
verilog/tracker_top.sv
bench/tracker_chk.sv
bench/tb_tracker.sv

/* bench/tb_tracker.sv */
/*
 * Tracker vision testbench
 * Frame-buffer model, frame patterns, reference models for the pixel
 * path and the per-frame classification, raster and address checks
 */
`timescale 1ns/100ps

module tb_tracker;

  // Small raster of 20 cycles per line and 10 lines per frame
  localparam int h_active     = 12;
  localparam int h_total      = 12 + 2 + 3 + 3;
  localparam int v_active     = 6;
  localparam int v_total      = 6 + 1 + 2 + 1;
  localparam int detect_min   = 4;
  localparam int n_pixels     = h_active * v_active;
  localparam int frame_cycles = h_total * v_total;
  localparam int period       = 20;
  localparam int watchdog_ns  = (16 + 12 * frame_cycles) * period;
  localparam logic [11:0] orange_word = 12'hf72;

  logic                     clk;
  logic                     reset;
  logic [11:0]              pixel_data;
  logic [16:0]              rd_address;
  logic                     vga_hsync;
  logic                     vga_vsync;
  logic                     vga_blank_n;
  logic [7:0]               vga_r;
  logic [7:0]               vga_g;
  logic [7:0]               vga_b;
  logic                     target_detected;
  vision_pkg::direction_t   target_direction;
  logic [17:0]              orange_count;

  logic [11:0] mem [0:n_pixels-1];
  logic [16:0] read_addr = '0;
  integer      seed;
  string       test_name;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          test_errors = 0;

  // Compare process state
  int          pix_index = 0;
  int          h_cnt = 0;
  int          v_cnt = 0;
  int          run = 0;
  int          lines = 0;
  logic        h_seen = 0;
  logic        v_seen = 0;
  logic        h_prev = 1;
  logic        v_prev = 1;
  logic [16:0] addr_d1 = '0;
  logic [16:0] addr_d2 = '0;
  logic [24:0] colour;

  tracker_top #(
    .h_active   (h_active),
    .h_front    (2),
    .h_sync     (3),
    .h_back     (3),
    .v_active   (v_active),
    .v_front    (1),
    .v_sync     (2),
    .v_back     (1),
    .detect_min (detect_min)
  ) i_tracker_top (.*);

  always #(period / 2) clk = ~clk;

  // Frame buffer returns the word at the previous cycle's address just after the edge
  always @(posedge clk) begin
    #2;
    pixel_data = (read_addr < n_pixels) ? mem[read_addr] : 12'h000;
    read_addr = rd_address;
  end

  task automatic check(input string what, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      test_errors++;
      $display("FAILED %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
    end
  endtask

  // Orange flag on top of the 24-bit colour
  function automatic logic [24:0] pixel_colour(input logic [11:0] w);
    int r;
    int g;
    int b;
    r = w[11:8];
    g = w[7:4];
    b = w[3:0];
    if (r >= 12 && g >= 4 && g <= 10 && b <= 5) begin
      return {1'b1, 24'hff0000};
    end
    return {1'b0, 8'(r * 17), 8'(g * 17), 8'(b * 17)};
  endfunction

  // Packed as {detected, direction, count}
  function automatic logic [21:0] frame_summary();
    int          band [3];
    int          total;
    int          col;
    logic [24:0] p;
    logic [2:0]  dir;
    band = '{0, 0, 0};
    total = 0;
    for (int i = 0; i < n_pixels; i++) begin
      p = pixel_colour(mem[i]);
      col = i % h_active;
      if (p[24]) begin
        total++;
        if (col < h_active / 3) band[0]++;
        else if (col < (2 * h_active) / 3) band[1]++;
        else band[2]++;
      end
    end
    // Center takes ties, then left
    if (total < detect_min) dir = 3'b000;
    else if (band[1] >= band[0] && band[1] >= band[2]) dir = 3'b010;
    else if (band[0] >= band[2]) dir = 3'b100;
    else dir = 3'b001;
    return {total >= detect_min, dir, 18'(total)};
  endfunction

  // 0 random, 1 no orange, 2..4 block in left/center/right, 5 three pixels
  task automatic load_frame(input int kind);
    logic [31:0] r;
    int          start;
    for (int i = 0; i < n_pixels; i++) begin
      // Background keeps red at 7 or below
      mem[i] = 12'((i * 37) % 2048);
      if (kind == 0) begin
        r = $random(seed);
        mem[i] = r[11:0];
        if (r[15]) mem[i][11:8] = mem[i][11:8] | 4'hc;
      end
    end
    if (kind >= 2 && kind <= 4) begin
      start = (kind - 2) * (h_active / 3);
      for (int row = 1; row < 5; row++) begin
        for (int col = start; col < start + 4; col++) begin
          mem[row * h_active + col] = orange_word;
        end
      end
      // One stray pixel in the next band over
      mem[(start + 5) % h_active] = orange_word;
    end
    if (kind == 5) begin
      mem[5] = orange_word;
      mem[30] = orange_word;
      mem[66] = orange_word;
    end
  endtask

  task automatic report_test();
    tests++;
    if (test_errors == 0) begin
      $display("test %s passed", test_name);
    end else begin
      $display("test %s had %0d mismatches", test_name, test_errors);
    end
    test_errors = 0;
  endtask

  // Results land one clock after the vga_vsync fall
  task automatic finish_frame(input int next_kind, input string next_name);
    logic [21:0] expected;
    expected = frame_summary();
    @(negedge vga_vsync);
    @(posedge clk);
    #2;
    check("count", expected[17:0], orange_count);
    check("direction", expected[20:18], target_direction);
    check("detected", expected[21], target_detected);
    report_test();
    load_frame(next_kind);
    test_name = next_name;
  endtask

  // Raster timing, address order and pixel colour checked two cycles behind active
  always @(negedge clk) begin
    if (reset) begin
      pix_index = 0;
      run = 0;
      lines = 0;
      h_seen = 0;
      v_seen = 0;
    end else begin
      h_cnt++;
      v_cnt++;
      if (h_prev && !vga_hsync) begin
        if (h_seen) check("hsync period", h_total, h_cnt);
        h_seen = 1;
        h_cnt = 0;
      end
      if (v_prev && !vga_vsync) begin
        if (v_seen) check("vsync period", frame_cycles, v_cnt);
        check("active lines", v_active, lines);
        v_seen = 1;
        v_cnt = 0;
        lines = 0;
        pix_index = 0;
      end
      if (vga_blank_n) begin
        check("address", pix_index, addr_d2);
        colour = pixel_colour(mem[pix_index]);
        check("colour", colour[23:0], {vga_r, vga_g, vga_b});
        pix_index++;
        run++;
      end else if (run != 0) begin
        check("active run", h_active, run);
        run = 0;
        lines++;
      end
    end
    h_prev = vga_hsync;
    v_prev = vga_vsync;
    addr_d2 = addr_d1;
    addr_d1 = rd_address;
  end

  initial begin
    #(watchdog_ns);
    $display("Watchdog expired after %0d ns, frame end never arrived", watchdog_ns);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    pixel_data = '0;
    seed = 38526;
    test_name = "random_frame";
    load_frame(0);
    repeat (16) @(posedge clk);
    #2 reset = 1'b0;
    finish_frame(1, "empty_frame");
    finish_frame(5, "three_pixels");
    finish_frame(2, "left_block");
    finish_frame(3, "center_block");
    finish_frame(4, "right_block");
    finish_frame(0, "mid_reset");
    // Reset from late in the last active line until past the vsync edge
    // Held right band detection must clear as well
    repeat (v_active) @(posedge vga_blank_n);
    repeat (3) @(posedge clk);
    #2 reset = 1'b1;
    repeat (2 * h_total) begin
      @(posedge clk);
      #2;
      check("reset hsync", 1, vga_hsync);
      check("reset vsync", 1, vga_vsync);
      check("reset blank_n", 0, vga_blank_n);
      check("reset colour", 0, {vga_r, vga_g, vga_b});
      check("reset address", 0, rd_address);
      check("reset detection", 0, {target_detected, target_direction, orange_count});
    end
    reset = 1'b0;
    finish_frame(0, "spare_frame");
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* bench/tracker_chk.sv */
/*
 * Tracker assertions
 * Sync pulse width, black during blank, legal direction codes
 */
`timescale 1ns/100ps

module tracker_chk #(
  parameter int h_sync = 96
) (
  input logic       clk,
  input logic       reset,
  input logic       vga_hsync,
  input logic       vga_blank_n,
  input logic [7:0] vga_r,
  input logic [7:0] vga_g,
  input logic [7:0] vga_b,
  input logic       target_detected,
  input logic [2:0] target_direction
);

  // Line sync is exactly h_sync clocks wide
  hsync_width: assert property (@(posedge clk) disable iff (reset)
    $fell(vga_hsync) |-> (!vga_hsync [*h_sync]) ##1 vga_hsync)
    else $error("hsync pulse is not %0d cycles wide", h_sync);

  // No colour outside the active area
  blank_black: assert property (@(posedge clk) disable iff (reset)
    !vga_blank_n |-> (vga_r == 8'd0) && (vga_g == 8'd0) && (vga_b == 8'd0))
    else $error("colour output nonzero during blank");

  // None or exactly one band
  direction_code: assert property (@(posedge clk) disable iff (reset)
    target_direction inside {3'b000, 3'b100, 3'b010, 3'b001})
    else $error("illegal direction code %b", target_direction);

  detect_matches: assert property (@(posedge clk) disable iff (reset)
    target_detected == (target_direction != 3'b000))
    else $error("target_detected disagrees with target_direction");

endmodule

bind tracker_top tracker_chk #(
  .h_sync (h_sync)
) u_tracker_chk (
  .clk              (clk),
  .reset            (reset),
  .vga_hsync        (vga_hsync),
  .vga_blank_n      (vga_blank_n),
  .vga_r            (vga_r),
  .vga_g            (vga_g),
  .vga_b            (vga_b),
  .target_detected  (target_detected),
  .target_direction (target_direction)
);

/* verilog/tracker_top.sv */
/*
 * Tracker vision top level
 * Raster timing, frame-buffer addressing, orange marking and
 * per-frame direction classification on a single clock
 */
`timescale 1ns/100ps

module tracker_top #(
  parameter int h_active   = 640,
  parameter int h_front    = 16,
  parameter int h_sync     = 96,
  parameter int h_back     = 48,
  parameter int v_active   = 480,
  parameter int v_front    = 10,
  parameter int v_sync     = 2,
  parameter int v_back     = 33,
  parameter int detect_min = 64
) (
  input  logic                       clk,
  input  logic                       reset,
  input  video_pkg::pixel12_t        pixel_data,
  output video_pkg::fb_address_t     rd_address,
  output logic                       vga_hsync,
  output logic                       vga_vsync,
  output logic                       vga_blank_n,
  output video_pkg::channel_t        vga_r,
  output video_pkg::channel_t        vga_g,
  output video_pkg::channel_t        vga_b,
  output logic                       target_detected,
  output vision_pkg::direction_t     target_direction,
  output vision_pkg::pixel_count_t   orange_count
);

  // Raster before the memory read
  logic hsync;
  logic vsync;
  logic active;

  // Marker results, aligned with the VGA outputs
  logic is_orange;
  logic pix_active;

  vga_timing #(
    .h_active (h_active),
    .h_front  (h_front),
    .h_sync   (h_sync),
    .h_back   (h_back),
    .v_active (v_active),
    .v_front  (v_front),
    .v_sync   (v_sync),
    .v_back   (v_back)
  ) u_vga_timing (
    .clk    (clk),
    .reset  (reset),
    .hsync  (hsync),
    .vsync  (vsync),
    .active (active)
  );

  frame_address_gen u_frame_address_gen (
    .clk        (clk),
    .reset      (reset),
    .active     (active),
    .vsync      (vsync),
    .rd_address (rd_address)
  );

  // pixel_data returns here one clock after rd_address
  orange_marker u_orange_marker (
    .clk         (clk),
    .reset       (reset),
    .pixel_data  (pixel_data),
    .active      (active),
    .hsync       (hsync),
    .vsync       (vsync),
    .vga_r       (vga_r),
    .vga_g       (vga_g),
    .vga_b       (vga_b),
    .vga_hsync   (vga_hsync),
    .vga_vsync   (vga_vsync),
    .vga_blank_n (vga_blank_n),
    .is_orange   (is_orange),
    .pix_active  (pix_active)
  );

  // Frame end taken from the delayed vsync so the last pixels count
  direction_classifier #(
    .h_active   (h_active),
    .detect_min (detect_min)
  ) u_direction_classifier (
    .clk              (clk),
    .reset            (reset),
    .is_orange        (is_orange),
    .pix_active       (pix_active),
    .vsync            (vga_vsync),
    .target_detected  (target_detected),
    .target_direction (target_direction),
    .orange_count     (orange_count)
  );

endmodule

/* target/direction_classifier.sv */
/*
 * Direction classifier
 * Accumulates orange pixels per frame in left, center and right
 * column bands and reports count, detection and direction at frame end
 */
`timescale 1ns/100ps

module direction_classifier #(
  parameter int h_active   = 640,
  parameter int detect_min = 64
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       is_orange,
  input  logic                       pix_active,
  input  logic                       vsync,
  output logic                       target_detected,
  output vision_pkg::direction_t     target_direction,
  output vision_pkg::pixel_count_t   orange_count
);

  // Band edges, left is below edge_1 and center below edge_2
  localparam int edge_1 = h_active / 3;
  localparam int edge_2 = (2 * h_active) / 3;

  video_pkg::coord_t        col;
  vision_pkg::pixel_count_t left_sum;
  vision_pkg::pixel_count_t center_sum;
  vision_pkg::pixel_count_t right_sum;
  vision_pkg::pixel_count_t total;
  vision_pkg::direction_t   winner;
  logic                     vsync_q;
  logic                     frame_done;
  logic                     in_left;
  logic                     in_center;
  logic                     detected;

  // Column within the line, rests at zero during blank
  always_ff @(posedge clk) begin
    if (reset) begin
      col <= '0;
    end else if (pix_active) begin
      col <= col + 11'd1;
    end else begin
      col <= '0;
    end
  end

  assign in_left   = (col < video_pkg::coord_t'(edge_1));
  assign in_center = (col < video_pkg::coord_t'(edge_2)) && !in_left;

  // Frame end marker
  always_ff @(posedge clk) begin
    if (reset) begin
      vsync_q <= 1'b1;
    end else begin
      vsync_q <= vsync;
    end
  end

  assign frame_done = vsync_q & ~vsync;

  // Band accumulators, cleared once the frame has been reported
  always_ff @(posedge clk) begin
    if (reset || frame_done) begin
      left_sum   <= '0;
      center_sum <= '0;
      right_sum  <= '0;
    end else if (pix_active && is_orange) begin
      if (in_left) begin
        left_sum <= left_sum + 18'd1;
      end else if (in_center) begin
        center_sum <= center_sum + 18'd1;
      end else begin
        right_sum <= right_sum + 18'd1;
      end
    end
  end

  assign total    = left_sum + center_sum + right_sum;
  assign detected = (total >= vision_pkg::pixel_count_t'(detect_min));

  // Largest band; center wins ties, then left
  always_comb begin
    if (!detected) begin
      winner = vision_pkg::dir_none;
    end else if ((center_sum >= left_sum) && (center_sum >= right_sum)) begin
      winner = vision_pkg::dir_center;
    end else if (left_sum >= right_sum) begin
      winner = vision_pkg::dir_left;
    end else begin
      winner = vision_pkg::dir_right;
    end
  end

  // Results held for a whole frame
  always_ff @(posedge clk) begin
    if (reset) begin
      target_detected  <= 1'b0;
      target_direction <= vision_pkg::dir_none;
      orange_count     <= '0;
    end else if (frame_done) begin
      target_detected  <= detected;
      target_direction <= winner;
      orange_count     <= total;
    end
  end

endmodule

/* target/orange_marker.sv */
/*
 * Orange marker
 * Aligns raster control with the returning frame-buffer word,
 * tests it against the orange window and drives the VGA pixel
 */
`timescale 1ns/100ps

module orange_marker (
  input  logic                  clk,
  input  logic                  reset,
  input  video_pkg::pixel12_t   pixel_data,
  input  logic                  active,
  input  logic                  hsync,
  input  logic                  vsync,
  output video_pkg::channel_t   vga_r,
  output video_pkg::channel_t   vga_g,
  output video_pkg::channel_t   vga_b,
  output logic                  vga_hsync,
  output logic                  vga_vsync,
  output logic                  vga_blank_n,
  output logic                  is_orange,
  output logic                  pix_active
);

  logic       active_d;
  logic       hsync_d;
  logic       vsync_d;
  logic [3:0] red_n;
  logic [3:0] green_n;
  logic [3:0] blue_n;
  logic       orange_hit;

  // Stage 1, raster control waits out the memory read
  always_ff @(posedge clk) begin
    if (reset) begin
      active_d <= 1'b0;
      hsync_d  <= 1'b1;
      vsync_d  <= 1'b1;
    end else begin
      active_d <= active;
      hsync_d  <= hsync;
      vsync_d  <= vsync;
    end
  end

  // Split the stored word
  assign red_n   = pixel_data[11:8];
  assign green_n = pixel_data[7:4];
  assign blue_n  = pixel_data[3:0];

  // Orange window test
  assign orange_hit = (red_n >= vision_pkg::red_min) &&
                      (green_n >= vision_pkg::green_min) &&
                      (green_n <= vision_pkg::green_max) &&
                      (blue_n <= vision_pkg::blue_max);

  // Stage 2, output register
  // Nibble repeat maps 0..15 onto 0..255 (n * 17)
  always_ff @(posedge clk) begin
    if (reset) begin
      vga_r       <= '0;
      vga_g       <= '0;
      vga_b       <= '0;
      vga_hsync   <= 1'b1;
      vga_vsync   <= 1'b1;
      vga_blank_n <= 1'b0;
      is_orange   <= 1'b0;
    end else begin
      vga_hsync   <= hsync_d;
      vga_vsync   <= vsync_d;
      vga_blank_n <= active_d;
      is_orange   <= active_d & orange_hit;
      if (!active_d) begin
        vga_r <= '0;
        vga_g <= '0;
        vga_b <= '0;
      end else if (orange_hit) begin
        {vga_r, vga_g, vga_b} <= vision_pkg::mark_colour;
      end else begin
        vga_r <= {red_n, red_n};
        vga_g <= {green_n, green_n};
        vga_b <= {blue_n, blue_n};
      end
    end
  end

  // Qualifier for the classifier, same cycle as the pixel
  assign pix_active = vga_blank_n;

endmodule

/* vga/frame_address_gen.sv */
/*
 * Frame-buffer read address
 * Counts active pixels issued in the frame, restarts on vsync fall
 */
`timescale 1ns/100ps

module frame_address_gen (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     active,
  input  logic                     vsync,
  output video_pkg::fb_address_t   rd_address
);

  video_pkg::fb_address_t pixel_index;
  logic                   vsync_q;
  logic                   vsync_fall;

  // Previous vsync for edge detect
  always_ff @(posedge clk) begin
    if (reset) begin
      vsync_q <= 1'b1;
    end else begin
      vsync_q <= vsync;
    end
  end

  assign vsync_fall = vsync_q & ~vsync;

  // Frame restart wins, it only happens in vertical blank anyway
  always_ff @(posedge clk) begin
    if (reset) begin
      pixel_index <= '0;
    end else if (vsync_fall) begin
      pixel_index <= '0;
    end else if (active) begin
      pixel_index <= pixel_index + 17'd1;
    end
  end

  // Address is valid in the active cycle itself
  // Memory returns the word on the next clock
  assign rd_address = pixel_index;

endmodule

/* vga/vga_timing.sv */
/*
 * VGA timing
 * Column and row counters over the full line and frame totals,
 * decoded into registered active-low syncs and the active-area level
 */
`timescale 1ns/100ps

module vga_timing #(
  parameter int h_active = 640,
  parameter int h_front  = 16,
  parameter int h_sync   = 96,
  parameter int h_back   = 48,
  parameter int v_active = 480,
  parameter int v_front  = 10,
  parameter int v_sync   = 2,
  parameter int v_back   = 33
) (
  input  logic clk,
  input  logic reset,
  output logic hsync,
  output logic vsync,
  output logic active
);

  // Line and frame lengths
  localparam int h_total = h_active + h_front + h_sync + h_back;
  localparam int v_total = v_active + v_front + v_sync + v_back;

  // Sync windows, start inclusive and end exclusive
  localparam int h_sync_start = h_active + h_front;
  localparam int h_sync_end   = h_sync_start + h_sync;
  localparam int v_sync_start = v_active + v_front;
  localparam int v_sync_end   = v_sync_start + v_sync;

  video_pkg::coord_t col;
  video_pkg::coord_t row;

  logic line_end;
  logic frame_end;
  logic h_in_sync;
  logic v_in_sync;
  logic in_active;

  assign line_end  = (col == video_pkg::coord_t'(h_total - 1));
  assign frame_end = (row == video_pkg::coord_t'(v_total - 1));

  // Column wraps each line, row steps on each line wrap
  always_ff @(posedge clk) begin
    if (reset) begin
      col <= '0;
      row <= '0;
    end else if (line_end) begin
      col <= '0;
      if (frame_end) begin
        row <= '0;
      end else begin
        row <= row + 11'd1;
      end
    end else begin
      col <= col + 11'd1;
    end
  end

  // Decode from the current count
  assign h_in_sync = (col >= video_pkg::coord_t'(h_sync_start)) &&
                     (col <  video_pkg::coord_t'(h_sync_end));
  assign v_in_sync = (row >= video_pkg::coord_t'(v_sync_start)) &&
                     (row <  video_pkg::coord_t'(v_sync_end));
  assign in_active = (col < video_pkg::coord_t'(h_active)) &&
                     (row < video_pkg::coord_t'(v_active));

  // Registered levels, all three share the same one-cycle lag
  // so their relative timing matches the counters exactly
  always_ff @(posedge clk) begin
    if (reset) begin
      hsync  <= 1'b1;
      vsync  <= 1'b1;
      active <= 1'b0;
    end else begin
      hsync  <= ~h_in_sync;
      vsync  <= ~v_in_sync;
      active <= in_active;
    end
  end

endmodule

/* common/vision_pkg.sv */
/*
 * Vision constants
 * Orange colour window on the 4-bit channels, overlay colour,
 * direction code and orange pixel count type
 */
package vision_pkg;

  // Orange window, applied to each 4-bit channel
  // Strong red, moderate green, little blue
  localparam logic [3:0] red_min   = 4'd12;
  localparam logic [3:0] green_min = 4'd4;
  localparam logic [3:0] green_max = 4'd10;
  localparam logic [3:0] blue_max  = 4'd5;

  // Overlay painted on matching pixels
  // Packed as {red, green, blue}
  localparam logic [23:0] mark_colour = 24'hff_00_00;

  // Direction of the largest orange band
  // One-hot across left, center, right so it can drive LEDs directly
  typedef enum logic [2:0] {
    dir_none   = 3'b000,
    dir_left   = 3'b100,
    dir_center = 3'b010,
    dir_right  = 3'b001
  } direction_t;

  // Orange pixels seen in one frame
  typedef logic [17:0] pixel_count_t;

endpackage

/* common/video_pkg.sv */
/*
 * Video types
 * Raster counter, frame-buffer address, stored pixel and VGA channel
 * widths shared by the timing, address and colour blocks
 */
package video_pkg;

  // Stored camera pixel, 4 bits per channel
  // Red in [11:8], green in [7:4], blue in [3:0]
  typedef logic [11:0] pixel12_t;

  // One 8-bit channel as driven to the VGA DAC
  typedef logic [7:0] channel_t;

  // Frame-buffer word address
  // 320 x 240 = 76800 words needs 17 bits
  typedef logic [16:0] fb_address_t;

  // Raster column or row counter
  // 11 bits covers line totals up to 2047
  typedef logic [10:0] coord_t;

endpackage
